// File: ttc_regs_pkg.sv
// ttc register map: bus address width, register offsets and interrupt bit positions
`default_nettype none

package ttc_regs_pkg;

  // ------------------------------------------------
  // bus geometry
  // ------------------------------------------------

  // apb address width, byte addressed
  localparam int ADDR_W = 8;

  // ------------------------------------------------
  // register offsets, one word each
  // ------------------------------------------------

  localparam logic [ADDR_W-1:0] CLK_CTRL_ADDR   = 8'h00;
  localparam logic [ADDR_W-1:0] CNTR_CTRL_ADDR  = 8'h04;
  // read only, free running count
  localparam logic [ADDR_W-1:0] COUNTER_ADDR    = 8'h08;
  localparam logic [ADDR_W-1:0] INTERVAL_ADDR   = 8'h0C;
  // read clears the sticky bits
  localparam logic [ADDR_W-1:0] INT_STATUS_ADDR = 8'h10;
  localparam logic [ADDR_W-1:0] INT_ENABLE_ADDR = 8'h14;

  // ------------------------------------------------
  // interrupt status / enable layout
  // ------------------------------------------------

  // width of status and enable fields
  localparam int INT_W            = 2;
  // counter matched the interval
  localparam int INT_INTERVAL_BIT = 0;
  // counter wrapped past all ones
  localparam int INT_OVERFLOW_BIT = 1;

endpackage : ttc_regs_pkg

`default_nettype wire

// File: ttc_clk_pkg.sv
// ttc clock and counter control field layout shared by the control path blocks
`default_nettype none

package ttc_clk_pkg;

  // ------------------------------------------------
  // clock control register
  // ------------------------------------------------

  // 7 bit register, bits 5 and 6 kept for readback only
  localparam int CLK_CTRL_W = 7;

  // prescaler enable
  localparam int PS_EN_BIT  = 0;
  // prescale value N, divide by 2^(N+1)
  localparam int PS_VAL_LSB = 1;
  localparam int PS_VAL_W   = 4;

  // ------------------------------------------------
  // counter control register
  // ------------------------------------------------

  // 5 bit register, bits 2 and 3 stored only
  localparam int CNTR_CTRL_W = 5;

  // stop counting, value holds
  localparam int CNT_DIS_BIT       = 0;
  // wrap at interval instead of all ones
  localparam int INTERVAL_MODE_BIT = 1;
  // level request, restart on rising edge
  localparam int RESTART_BIT       = 4;

endpackage : ttc_clk_pkg

`default_nettype wire

// File: ttc_apb_regs.sv
// ttc apb slave: address decode, control and interval registers, read mux, interrupt status
`default_nettype none

module ttc_apb_regs #(
  parameter int COUNT_WIDTH = 16
) (
  input  wire logic                             pclk27,
  input  wire logic                             n_p_reset27,
  input  wire logic [ttc_regs_pkg::ADDR_W-1:0]  paddr,
  input  wire logic                             psel,
  input  wire logic                             penable,
  input  wire logic                             pwrite,
  input  wire logic [COUNT_WIDTH-1:0]           pwdata,
  output logic      [COUNT_WIDTH-1:0]           prdata,
  output logic                                  clk_ctrl_reg_sel,
  input  wire logic [ttc_clk_pkg::CLK_CTRL_W-1:0] clk_ctrl_reg_out,
  output logic                                  restart,
  output logic                                  cnt_dis,
  output logic                                  interval_mode,
  output logic      [COUNT_WIDTH-1:0]           interval,
  input  wire logic [COUNT_WIDTH-1:0]           count_value,
  input  wire logic                             interval_event,
  input  wire logic                             overflow_event,
  output logic                                  irq
);

  import ttc_regs_pkg::*;
  import ttc_clk_pkg::*;

  // ------------------------------------------------
  // access strobes
  // ------------------------------------------------

  logic                   wr_en;
  logic                   rd_en;
  logic                   status_rd;
  logic [CNTR_CTRL_W-1:0] cntr_ctrl_q;
  logic [COUNT_WIDTH-1:0] interval_q;
  logic [INT_W-1:0]       int_enable_q;
  logic [INT_W-1:0]       int_status_q;
  logic [INT_W-1:0]       int_events;

  // access phase only, one cycle per transfer
  assign wr_en     = psel & penable & pwrite;
  assign rd_en     = psel & penable & ~pwrite;
  assign status_rd = rd_en & (paddr == INT_STATUS_ADDR);

  // clock control lives in the restart block
  assign clk_ctrl_reg_sel = wr_en & (paddr == CLK_CTRL_ADDR);

  // ------------------------------------------------
  // control, interval and enable registers
  // ------------------------------------------------

  always_ff @(posedge pclk27 or negedge n_p_reset27)
  begin
    if (!n_p_reset27)
    begin
      cntr_ctrl_q  <= '0;
      interval_q   <= '0;
      int_enable_q <= '0;
    end
    else if (wr_en)
    begin
      case (paddr)
        CNTR_CTRL_ADDR:  cntr_ctrl_q  <= pwdata[CNTR_CTRL_W-1:0];
        INTERVAL_ADDR:   interval_q   <= pwdata;
        INT_ENABLE_ADDR: int_enable_q <= pwdata[INT_W-1:0];
        default:         ;
      endcase
    end
  end

  // restart is a level, software drops it again
  assign restart       = cntr_ctrl_q[RESTART_BIT];
  assign cnt_dis       = cntr_ctrl_q[CNT_DIS_BIT];
  assign interval_mode = cntr_ctrl_q[INTERVAL_MODE_BIT];
  assign interval      = interval_q;

  // ------------------------------------------------
  // sticky status and irq
  // ------------------------------------------------

  always_comb
  begin
    int_events                   = '0;
    int_events[INT_INTERVAL_BIT] = interval_event;
    int_events[INT_OVERFLOW_BIT] = overflow_event;
  end

  // read clears, a same-cycle event still lands
  always_ff @(posedge pclk27 or negedge n_p_reset27)
  begin
    if (!n_p_reset27)
    begin
      int_status_q <= '0;
      irq          <= 1'b0;
    end
    else
    begin
      int_status_q <= (status_rd ? '0 : int_status_q) | int_events;
      irq          <= |(int_status_q & int_enable_q);
    end
  end

  // ------------------------------------------------
  // read mux
  // ------------------------------------------------

  always_comb
  begin
    prdata = '0;
    if (rd_en)
    begin
      case (paddr)
        CLK_CTRL_ADDR:   prdata = COUNT_WIDTH'(clk_ctrl_reg_out);
        CNTR_CTRL_ADDR:  prdata = COUNT_WIDTH'(cntr_ctrl_q);
        COUNTER_ADDR:    prdata = count_value;
        INTERVAL_ADDR:   prdata = interval_q;
        INT_STATUS_ADDR: prdata = COUNT_WIDTH'(int_status_q);
        INT_ENABLE_ADDR: prdata = COUNT_WIDTH'(int_enable_q);
        default:         prdata = '0;
      endcase
    end
  end

  // read data must be clean whenever the master samples it
  a_prdata_known: assert property (@(posedge pclk27) disable iff (!n_p_reset27)
    rd_en |-> !$isunknown(prdata));

  // status bits only come from counter events
  a_ivl_status_src: assert property (@(posedge pclk27) disable iff (!n_p_reset27)
    $rose(int_status_q[INT_INTERVAL_BIT]) |-> $past(interval_event));
  a_ovf_status_src: assert property (@(posedge pclk27) disable iff (!n_p_reset27)
    $rose(int_status_q[INT_OVERFLOW_BIT]) |-> $past(overflow_event));

endmodule : ttc_apb_regs

`default_nettype wire

// File: ttc_count_rst_lite.sv
// ttc clock control register and one-cycle counter enable drop on restart
`default_nettype none

module ttc_count_rst_lite #(
  parameter int COUNT_WIDTH = 16
) (
  input  wire logic                                pclk27,
  input  wire logic                                n_p_reset27,
  input  wire logic [COUNT_WIDTH-1:0]              pwdata,
  input  wire logic                                clk_ctrl_reg_sel,
  input  wire logic                                restart,
  output logic                                     count_en_out,
  output logic      [ttc_clk_pkg::CLK_CTRL_W-1:0]  clk_ctrl_reg_out
);

  import ttc_clk_pkg::*;

  // ------------------------------------------------
  // restart edge and enable
  // ------------------------------------------------

  // set on first restart cycle, held until restart drops
  logic restart_seen_q;
  logic count_en_q;

  always_ff @(posedge pclk27 or negedge n_p_reset27)
  begin
    if (!n_p_reset27)
    begin
      restart_seen_q <= 1'b0;
      count_en_q     <= 1'b0;
    end
    else if (restart && !restart_seen_q)
    begin
      // first restart cycle, kill enable once
      restart_seen_q <= 1'b1;
      count_en_q     <= 1'b0;
    end
    else
    begin
      // re-arm only once restart goes low
      restart_seen_q <= restart & restart_seen_q;
      count_en_q     <= 1'b1;
    end
  end

  assign count_en_out = count_en_q;

  // ------------------------------------------------
  // clock control register
  // ------------------------------------------------

  always_ff @(posedge pclk27 or negedge n_p_reset27)
  begin
    if (!n_p_reset27)
      clk_ctrl_reg_out <= '0;
    else if (clk_ctrl_reg_sel)
      clk_ctrl_reg_out <= pwdata[CLK_CTRL_W-1:0];
  end

  // enable drop is a single-cycle pulse, never stretched
  a_en_single_drop: assert property (@(posedge pclk27) disable iff (!n_p_reset27)
    !count_en_q |=> count_en_q);

endmodule : ttc_count_rst_lite

`default_nettype wire

// File: ttc_prescaler.sv
// ttc prescaler: divides pclk27 into count ticks per the clock control register
`default_nettype none

module ttc_prescaler (
  input  wire logic                                pclk27,
  input  wire logic                                n_p_reset27,
  input  wire logic [ttc_clk_pkg::CLK_CTRL_W-1:0]  clk_ctrl_reg_out,
  input  wire logic                                count_en,
  output logic                                     count_tick
);

  import ttc_clk_pkg::*;

  // ------------------------------------------------
  // divider geometry
  // ------------------------------------------------

  // largest division is 2^(2^PS_VAL_W), so 2^PS_VAL_W bits of phase
  localparam int DIV_W = 2 ** PS_VAL_W;

  logic                ps_en;
  logic [PS_VAL_W-1:0] ps_val;
  logic [DIV_W-1:0]    term_val;
  logic                at_term;
  logic [DIV_W-1:0]    div_q;

  assign ps_en  = clk_ctrl_reg_out[PS_EN_BIT];
  assign ps_val = clk_ctrl_reg_out[PS_VAL_LSB +: PS_VAL_W];

  // terminal = 2^(N+1)-1
  // all ones shifted right by (max - N), and ~N is exactly max - N
  assign term_val = {DIV_W{1'b1}} >> (~ps_val);
  // a phase left above a lowered terminal wraps at once
  assign at_term  = (div_q >= term_val);

  // ------------------------------------------------
  // phase counter
  // ------------------------------------------------

  always_ff @(posedge pclk27 or negedge n_p_reset27)
  begin
    if (!n_p_reset27)
      div_q <= '0;
    else if (!count_en || !ps_en)
      // held at zero while disabled or bypassed
      div_q <= '0;
    else if (at_term)
      div_q <= '0;
    else
      div_q <= div_q + 1'b1;
  end

  // ------------------------------------------------
  // tick
  // ------------------------------------------------

  // bypass gives a tick every enabled cycle
  assign count_tick = count_en & (~ps_en | at_term);

  // no ticks leak through the restart drop
  a_no_tick_when_off: assert property (@(posedge pclk27) disable iff (!n_p_reset27)
    !count_en |-> !count_tick);

endmodule : ttc_prescaler

`default_nettype wire

// File: ttc_counter.sv
// ttc up counter with interval or overflow wrap and one-cycle event pulses
`default_nettype none

module ttc_counter #(
  parameter int COUNT_WIDTH = 16
) (
  input  wire logic                   pclk27,
  input  wire logic                   n_p_reset27,
  input  wire logic                   count_en,
  input  wire logic                   count_tick,
  input  wire logic                   cnt_dis,
  input  wire logic                   interval_mode,
  input  wire logic [COUNT_WIDTH-1:0] interval,
  output logic      [COUNT_WIDTH-1:0] count_value,
  output logic                        interval_event,
  output logic                        overflow_event
);

  // ------------------------------------------------
  // wrap detection
  // ------------------------------------------------

  logic [COUNT_WIDTH-1:0] count_q;
  logic                   step;
  logic                   ivl_hit;
  logic                   ovf_hit;

  // stepping needs a tick and no disable
  assign step = count_tick & ~cnt_dis;

  // interval match wins over all ones when interval is max
  assign ivl_hit = interval_mode & (count_q == interval);
  assign ovf_hit = ~ivl_hit & (&count_q);

  // ------------------------------------------------
  // count register and events
  // ------------------------------------------------

  always_ff @(posedge pclk27 or negedge n_p_reset27)
  begin
    if (!n_p_reset27)
    begin
      count_q        <= '0;
      interval_event <= 1'b0;
      overflow_event <= 1'b0;
    end
    else if (!count_en)
    begin
      // restart drop clears the count
      count_q        <= '0;
      interval_event <= 1'b0;
      overflow_event <= 1'b0;
    end
    else
    begin
      // pulses last one cycle
      interval_event <= step & ivl_hit;
      overflow_event <= step & ovf_hit;
      if (step)
      begin
        if (ivl_hit)
          count_q <= '0;
        else
          // natural wrap covers overflow
          count_q <= count_q + 1'b1;
      end
    end
  end

  assign count_value = count_q;

  // ------------------------------------------------
  // checks
  // ------------------------------------------------

  // once at or under the interval, stays there while mode and interval hold
  a_ivl_bound: assert property (@(posedge pclk27) disable iff (!n_p_reset27)
    (interval_mode && count_q <= interval) ##1 (interval_mode && $stable(interval))
    |-> count_q <= interval);

  // an event always comes with the count back at zero
  a_evt_zero: assert property (@(posedge pclk27) disable iff (!n_p_reset27)
    (interval_event || overflow_event) |-> count_q == '0);

endmodule : ttc_counter

`default_nettype wire

// File: ttc_lite_top.sv
// ttc lite top: one counter channel behind an apb register slave
`default_nettype none

module ttc_lite_top #(
  parameter int COUNT_WIDTH = 16
) (
  input  wire logic                            pclk27,
  input  wire logic                            n_p_reset27,
  input  wire logic [ttc_regs_pkg::ADDR_W-1:0] paddr,
  input  wire logic                            psel,
  input  wire logic                            penable,
  input  wire logic                            pwrite,
  input  wire logic [COUNT_WIDTH-1:0]          pwdata,
  output logic      [COUNT_WIDTH-1:0]          prdata,
  output logic                                 irq
);

  // ------------------------------------------------
  // internal nets
  // ------------------------------------------------

  logic                                clk_ctrl_reg_sel;
  logic [ttc_clk_pkg::CLK_CTRL_W-1:0]  clk_ctrl_reg_out;
  logic                                restart;
  logic                                cnt_dis;
  logic                                interval_mode;
  logic [COUNT_WIDTH-1:0]              interval;
  logic                                count_en;
  logic                                count_tick;
  logic [COUNT_WIDTH-1:0]              count_value;
  logic                                interval_event;
  logic                                overflow_event;

  // ------------------------------------------------
  // blocks
  // ------------------------------------------------

  // register slave and irq
  ttc_apb_regs #(.COUNT_WIDTH(COUNT_WIDTH)) u_apb_regs (
    .pclk27, .n_p_reset27, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata,
    .clk_ctrl_reg_sel, .clk_ctrl_reg_out, .restart, .cnt_dis, .interval_mode,
    .interval, .count_value, .interval_event, .overflow_event, .irq
  );

  // clock control and restart pulse
  ttc_count_rst_lite #(.COUNT_WIDTH(COUNT_WIDTH)) u_count_rst (
    .pclk27, .n_p_reset27, .pwdata, .clk_ctrl_reg_sel, .restart,
    .count_en_out(count_en), .clk_ctrl_reg_out
  );

  // tick generation
  ttc_prescaler u_prescaler (
    .pclk27, .n_p_reset27, .clk_ctrl_reg_out, .count_en, .count_tick
  );

  // the count itself
  ttc_counter #(.COUNT_WIDTH(COUNT_WIDTH)) u_counter (
    .pclk27, .n_p_reset27, .count_en, .count_tick, .cnt_dis, .interval_mode,
    .interval, .count_value, .interval_event, .overflow_event
  );

endmodule : ttc_lite_top

`default_nettype wire

// File: ttc_lite_tb.sv
// ttc lite testbench: apb stimulus against one counter channel, checked by assertions
`default_nettype none

module ttc_lite_tb;

  import ttc_regs_pkg::*;
  import ttc_clk_pkg::*;

  localparam int CW         = 8;
  localparam int CLK_PERIOD = 20;
  localparam int WATCHDOG   = 4000;

  logic              pclk27;
  logic              n_p_reset27;
  logic [ADDR_W-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [CW-1:0]     pwdata;
  logic [CW-1:0]     prdata;
  logic              irq;

  int          errors = 0;
  int          assert_errors = 0;
  logic [31:0] rng_state = 32'd22725;
  time         read_time;

  // 8 bit count so overflow comes quickly
  ttc_lite_top #(.COUNT_WIDTH(CW)) uut (
    .pclk27, .n_p_reset27, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .irq
  );

  always #(CLK_PERIOD / 2) pclk27 = ~pclk27;

  // --------------------------------------------------
  // bus access and helpers
  // --------------------------------------------------

  // setup, access, then idle; write lands on the third edge
  task automatic write_reg(input logic [ADDR_W-1:0] addr, input int data);
    @(posedge pclk27);
    paddr   <= addr;
    pwdata  <= data[CW-1:0];
    pwrite  <= 1'b1;
    psel    <= 1'b1;
    @(posedge pclk27);
    penable <= 1'b1;
    @(posedge pclk27);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // prdata sampled mid access cycle, away from the edge
  task automatic read_reg(input logic [ADDR_W-1:0] addr, output int data);
    @(posedge pclk27);
    paddr   <= addr;
    pwrite  <= 1'b0;
    psel    <= 1'b1;
    @(posedge pclk27);
    penable <= 1'b1;
    @(negedge pclk27);
    data      = int'(prdata);
    read_time = $time;
    @(posedge pclk27);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // lcg, upper bits are the better ones
  function automatic int next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return int'(rng_state[30:15]);
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge pclk27);
  endtask

  // polls irq on falling edges
  // limit and cycles count rising edges after the call
  task automatic await_irq(input logic level, input int limit, output int cycles);
    cycles = 0;
    @(negedge pclk27);
    while (irq !== level && cycles < limit)
    begin
      @(negedge pclk27);
      cycles++;
    end
  endtask

  task automatic compare_value(input string name, input int expected, input int actual);
    assert (expected == actual)
    else
    begin
      errors++;
      $display("FAILED %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic check_at_most(input string name, input int limit, input int actual);
    assert (actual <= limit)
    else
    begin
      errors++;
      $display("FAILED %s expected <= %0h actual %0h", name, limit, actual);
    end
  endtask

  // --------------------------------------------------
  // bus level properties
  // --------------------------------------------------

  a_irq_known: assert property (@(posedge pclk27) disable iff (!n_p_reset27)
    !$isunknown(irq))
  else
  begin
    assert_errors++;
    $display("irq went unknown after reset");
  end

  a_read_known: assert property (@(posedge pclk27) disable iff (!n_p_reset27)
    (psel && penable && !pwrite) |-> !$isunknown(prdata))
  else
  begin
    assert_errors++;
    $display("read data was unknown during an access cycle");
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  initial
  begin
    int  rd;
    int  first;
    int  wr [4];
    int  ivl;
    int  ps_n;
    int  cycles;
    int  expect_ticks;
    int  got_ticks;
    time t_first;

    pclk27      = 1'b0;
    n_p_reset27 = 1'b0;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    repeat (3) @(posedge pclk27);
    n_p_reset27 <= 1'b1;

    // reset values; counter runs from release, one step per cycle at most
    read_reg(COUNTER_ADDR, rd);
    check_at_most("reset_counter", 8, rd);
    read_reg(CLK_CTRL_ADDR, rd);
    compare_value("reset_clk_ctrl", 0, rd);
    read_reg(CNTR_CTRL_ADDR, rd);
    compare_value("reset_cntr_ctrl", 0, rd);
    read_reg(INTERVAL_ADDR, rd);
    compare_value("reset_interval", 0, rd);
    read_reg(INT_STATUS_ADDR, rd);
    compare_value("reset_int_status", 0, rd);
    read_reg(INT_ENABLE_ADDR, rd);
    compare_value("reset_int_enable", 0, rd);
    compare_value("reset_irq", 0, int'(irq));

    // random readback, each register keeps only its own field
    for (int i = 0; i < 8; i++)
    begin
      wr[0] = next_rand() & 8'hFF;
      wr[1] = next_rand() & 8'hFF;
      wr[2] = next_rand() & 8'hFF;
      wr[3] = next_rand() & 8'hFF;
      write_reg(CLK_CTRL_ADDR, wr[0]);
      write_reg(CNTR_CTRL_ADDR, wr[1]);
      write_reg(INTERVAL_ADDR, wr[2]);
      write_reg(INT_ENABLE_ADDR, wr[3]);
      read_reg(CLK_CTRL_ADDR, rd);
      compare_value("readback_clk_ctrl", wr[0] & ((1 << CLK_CTRL_W) - 1), rd);
      read_reg(CNTR_CTRL_ADDR, rd);
      compare_value("readback_cntr_ctrl", wr[1] & ((1 << CNTR_CTRL_W) - 1), rd);
      read_reg(INTERVAL_ADDR, rd);
      compare_value("readback_interval", wr[2], rd);
      read_reg(INT_ENABLE_ADDR, rd);
      compare_value("readback_int_enable", wr[3] & ((1 << INT_W) - 1), rd);
    end
    write_reg(INT_ENABLE_ADDR, 0);
    write_reg(CLK_CTRL_ADDR, 0);
    write_reg(CNTR_CTRL_ADDR, 0);

    // restart clears the count, then disable freezes it
    write_reg(CNTR_CTRL_ADDR, 1 << RESTART_BIT);
    read_reg(COUNTER_ADDR, rd);
    check_at_most("restart_counter", 3, rd);
    write_reg(CNTR_CTRL_ADDR, 1 << CNT_DIS_BIT);
    idle_cycles(2);
    for (int i = 0; i < 4; i++)
    begin
      read_reg(COUNTER_ADDR, first);
      idle_cycles(1 + next_rand() % 16);
      read_reg(COUNTER_ADDR, rd);
      compare_value("disable_hold", first, rd);
    end

    // prescaled rate, N kept small so the count moves
    for (int i = 0; i < 3; i++)
    begin
      ps_n = next_rand() % 4;
      write_reg(CLK_CTRL_ADDR, (1 << PS_EN_BIT) | (ps_n << PS_VAL_LSB));
      write_reg(CNTR_CTRL_ADDR, 0);
      read_reg(COUNTER_ADDR, first);
      t_first = read_time;
      idle_cycles(20 + next_rand() % 60);
      read_reg(COUNTER_ADDR, rd);
      cycles       = int'((read_time - t_first) / CLK_PERIOD);
      expect_ticks = cycles >> (ps_n + 1);
      got_ticks    = (rd - first) & 8'hFF;
      assert (got_ticks <= expect_ticks + 1 && got_ticks + 1 >= expect_ticks)
      else
      begin
        errors++;
        $display("FAILED prescale_rate expected %0d +/- 1 actual %0d", expect_ticks, got_ticks);
      end
    end
    write_reg(CLK_CTRL_ADDR, 0);

    // interval mode, status cleared while frozen, then restart
    ivl = 3 + next_rand() % 18;
    write_reg(INTERVAL_ADDR, ivl);
    write_reg(CNTR_CTRL_ADDR, (1 << INTERVAL_MODE_BIT) | (1 << CNT_DIS_BIT));
    read_reg(INT_STATUS_ADDR, rd);
    write_reg(INT_ENABLE_ADDR, 1 << INT_INTERVAL_BIT);
    write_reg(CNTR_CTRL_ADDR, (1 << INTERVAL_MODE_BIT) | (1 << RESTART_BIT));
    // enable drop, clear, interval steps, event, status, irq
    await_irq(1'b1, ivl + 5, cycles);
    assert (irq === 1'b1)
    else
    begin
      errors++;
      $display("irq did not rise within %0d cycles of the interval restart", ivl + 5);
    end
    for (int i = 0; i < 4; i++)
    begin
      idle_cycles(next_rand() % 8);
      read_reg(COUNTER_ADDR, rd);
      check_at_most("interval_bound", ivl, rd);
    end
    write_reg(CNTR_CTRL_ADDR, (1 << INTERVAL_MODE_BIT) | (1 << CNT_DIS_BIT));
    read_reg(INT_STATUS_ADDR, rd);
    compare_value("interval_status_bit", 1, (rd >> INT_INTERVAL_BIT) & 1);
    await_irq(1'b0, 4, cycles);
    assert (irq === 1'b0)
    else
    begin
      errors++;
      $display("irq stayed high after the status read");
    end
    read_reg(INT_STATUS_ADDR, rd);
    compare_value("interval_status_clear", 0, rd);

    // overflow: 2 restart cycles, 256 steps, status and irq
    write_reg(CNTR_CTRL_ADDR, 1 << CNT_DIS_BIT);
    read_reg(INT_STATUS_ADDR, rd);
    write_reg(INT_ENABLE_ADDR, 1 << INT_OVERFLOW_BIT);
    write_reg(CNTR_CTRL_ADDR, 1 << RESTART_BIT);
    await_irq(1'b1, 260, cycles);
    assert (irq === 1'b1)
    else
    begin
      errors++;
      $display("irq did not rise within 260 cycles of the overflow restart");
    end
    read_reg(INT_STATUS_ADDR, rd);
    compare_value("overflow_status_bit", 1, (rd >> INT_OVERFLOW_BIT) & 1);

    $display("errors: %0d checks, %0d assertions", errors, assert_errors);
    if (errors == 0 && assert_errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  // hard stop well past the sum of all test lengths
  initial
  begin
    repeat (WATCHDOG) @(posedge pclk27);
    $display("watchdog timeout after %0d cycles, tests did not complete", WATCHDOG);
    $display("errors: %0d checks, %0d assertions", errors, assert_errors);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule : ttc_lite_tb

`default_nettype wire

// File: filelist.f
ttc_regs_pkg.sv
ttc_clk_pkg.sv
ttc_apb_regs.sv
ttc_count_rst_lite.sv
ttc_prescaler.sv
ttc_counter.sv
ttc_lite_top.sv
ttc_lite_tb.sv

// File: Bender.yml
package:
  name: ttc_lite

sources:
  - ttc_regs_pkg.sv
  - ttc_clk_pkg.sv
  - ttc_apb_regs.sv
  - ttc_count_rst_lite.sv
  - ttc_prescaler.sv
  - ttc_counter.sv
  - ttc_lite_top.sv
  - target: simulation
    files:
      - ttc_lite_tb.sv
